// File: rtl/la_isa_pkg.sv
`default_nettype none

package la_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [4:0] {
        OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
        OP_NOR, OP_AND, OP_OR, OP_XOR,
        OP_SLLI_W, OP_SRLI_W, OP_SRAI_W,
        OP_ADDI_W, OP_LU12I_W,
        OP_LD_W, OP_ST_W,
        OP_JIRL, OP_B, OP_BL, OP_BEQ, OP_BNE,
        OP_ILLEGAL
    } inst_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // Instruction formats, bit 31 first
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;                  // Also ui5 for immediate shifts
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_1ri20_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;             // Upper offset bits sit at the bottom
    } fmt_i26_t;

    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;
    localparam logic [5:0]  OPC_JIRL   = 6'h13;
    localparam logic [5:0]  OPC_B      = 6'h14;
    localparam logic [5:0]  OPC_BL     = 6'h15;
    localparam logic [5:0]  OPC_BEQ    = 6'h16;
    localparam logic [5:0]  OPC_BNE    = 6'h17;

endpackage

`default_nettype wire

// File: rtl/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    import la_isa_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } cpu_state_t;

    typedef struct packed {
        inst_op_t              op;
        alu_op_t               alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_from_rd;    // Port 2 reads rd instead of rk
        logic                  res_from_mem;
        logic                  mem_we;
        logic                  reg_we;
        logic                  is_branch;       // Any PC redirect, jirl included
        logic                  is_cond_branch;
        logic                  branch_on_eq;
        logic                  is_jirl;
        logic [REG_ADDR_W-1:0] dest;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       br_offs;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [3:0]            we;
        logic [REG_ADDR_W-1:0] wnum;
        logic [XLEN-1:0]       wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import la_isa_pkg::*;
    import cpu_ctrl_pkg::*;
(
    input  logic [XLEN-1:0] inst,
    output ctrl_t           ctrl
);

    fmt_3r_t    f_3r;
    fmt_2ri12_t f_2ri12;
    fmt_2ri16_t f_2ri16;
    fmt_1ri20_t f_1ri20;
    fmt_i26_t   f_i26;

    inst_op_t        op;
    alu_op_t         alu_op;
    logic [XLEN-1:0] imm_ui5;
    logic [XLEN-1:0] imm_si12;
    logic [XLEN-1:0] imm_si20;
    logic [XLEN-1:0] offs_si16;
    logic [XLEN-1:0] offs_si26;

    assign f_3r    = inst;
    assign f_2ri12 = inst;
    assign f_2ri16 = inst;
    assign f_1ri20 = inst;
    assign f_i26   = inst;

    assign imm_ui5   = {{(XLEN-5){1'b0}}, f_3r.rk};
    assign imm_si12  = {{(XLEN-12){f_2ri12.si12[11]}}, f_2ri12.si12};
    assign imm_si20  = {f_1ri20.si20, 12'b0};
    assign offs_si16 = {{(XLEN-18){f_2ri16.offs16[15]}}, f_2ri16.offs16, 2'b0};
    assign offs_si26 = {{(XLEN-28){f_i26.offs_hi[9]}}, f_i26.offs_hi, f_i26.offs_lo, 2'b0};

    always_comb begin
        if      (f_3r.opcode == OPC_ADD_W)      op = OP_ADD_W;
        else if (f_3r.opcode == OPC_SUB_W)      op = OP_SUB_W;
        else if (f_3r.opcode == OPC_SLT)        op = OP_SLT;
        else if (f_3r.opcode == OPC_SLTU)       op = OP_SLTU;
        else if (f_3r.opcode == OPC_NOR)        op = OP_NOR;
        else if (f_3r.opcode == OPC_AND)        op = OP_AND;
        else if (f_3r.opcode == OPC_OR)         op = OP_OR;
        else if (f_3r.opcode == OPC_XOR)        op = OP_XOR;
        else if (f_3r.opcode == OPC_SLLI_W)     op = OP_SLLI_W;
        else if (f_3r.opcode == OPC_SRLI_W)     op = OP_SRLI_W;
        else if (f_3r.opcode == OPC_SRAI_W)     op = OP_SRAI_W;
        else if (f_2ri12.opcode == OPC_ADDI_W)  op = OP_ADDI_W;
        else if (f_2ri12.opcode == OPC_LD_W)    op = OP_LD_W;
        else if (f_2ri12.opcode == OPC_ST_W)    op = OP_ST_W;
        else if (f_1ri20.opcode == OPC_LU12I_W) op = OP_LU12I_W;
        else if (f_2ri16.opcode == OPC_JIRL)    op = OP_JIRL;
        else if (f_i26.opcode == OPC_B)         op = OP_B;
        else if (f_i26.opcode == OPC_BL)        op = OP_BL;
        else if (f_2ri16.opcode == OPC_BEQ)     op = OP_BEQ;
        else if (f_2ri16.opcode == OPC_BNE)     op = OP_BNE;
        else                                    op = OP_ILLEGAL;
    end

    always_comb begin
        case (op)
            OP_SUB_W:   alu_op = ALU_SUB;
            OP_SLT:     alu_op = ALU_SLT;
            OP_SLTU:    alu_op = ALU_SLTU;
            OP_NOR:     alu_op = ALU_NOR;
            OP_AND:     alu_op = ALU_AND;
            OP_OR:      alu_op = ALU_OR;
            OP_XOR:     alu_op = ALU_XOR;
            OP_SLLI_W:  alu_op = ALU_SLL;
            OP_SRLI_W:  alu_op = ALU_SRL;
            OP_SRAI_W:  alu_op = ALU_SRA;
            OP_LU12I_W: alu_op = ALU_LUI;
            default:    alu_op = ALU_ADD;   // Address and link sums too
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.op     = op;
        ctrl.alu_op = alu_op;
        ctrl.rj     = f_3r.rj;
        ctrl.rk     = f_3r.rk;
        ctrl.rd     = f_3r.rd;
        ctrl.dest   = f_3r.rd;
        case (op)
            OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_NOR, OP_AND, OP_OR, OP_XOR: begin
                ctrl.reg_we = 1'b1;
            end
            OP_SLLI_W, OP_SRLI_W, OP_SRAI_W: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = imm_ui5;
                ctrl.reg_we      = 1'b1;
            end
            OP_ADDI_W, OP_LD_W: begin
                ctrl.src2_is_imm  = 1'b1;
                ctrl.imm          = imm_si12;
                ctrl.res_from_mem = (op == OP_LD_W);
                ctrl.reg_we       = 1'b1;
            end
            OP_ST_W: begin
                ctrl.src2_is_imm  = 1'b1;
                ctrl.imm          = imm_si12;
                ctrl.src2_from_rd = 1'b1;  // Store data comes from rd
                ctrl.mem_we       = 1'b1;
            end
            OP_LU12I_W: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = imm_si20;
                ctrl.reg_we      = 1'b1;
            end
            OP_JIRL, OP_BL: begin
                ctrl.src1_is_pc  = 1'b1;    // Link value is pc + 4
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;
                ctrl.reg_we      = 1'b1;
                ctrl.is_branch   = 1'b1;
                ctrl.is_jirl     = (op == OP_JIRL);
                ctrl.br_offs     = (op == OP_JIRL) ? offs_si16 : offs_si26;
                if (op == OP_BL) begin
                    ctrl.dest = 5'd1;
                end
            end
            OP_B: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_offs   = offs_si26;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.src2_from_rd   = 1'b1;
                ctrl.is_branch      = 1'b1;
                ctrl.is_cond_branch = 1'b1;
                ctrl.branch_on_eq   = (op == OP_BEQ);
                ctrl.br_offs        = offs_si16;
            end
            default: begin
            end
        endcase
        if (ctrl.dest == '0) begin
            ctrl.reg_we = 1'b0;             // r0 is never written
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import la_isa_pkg::*;
(
    input  alu_op_t         alu_op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = src1 + src2;
            end
            ALU_SUB: begin
                result = src1 - src2;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_AND: result = src1 & src2;
            ALU_NOR: result = ~(src1 | src2);
            ALU_OR:  result = src1 | src2;
            ALU_XOR: result = src1 ^ src2;
            ALU_SLL: begin
                result = src1 << shamt;
            end
            ALU_SRL: begin
                result = src1 >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(src1) >>> shamt);
            end
            ALU_LUI: result = src2;         // Immediate already shifted by decoder
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile
    import la_isa_pkg::*;
(
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    output logic [XLEN-1:0]       rdata1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import la_isa_pkg::*;
    import cpu_ctrl_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    cpu_state_t state;
    cpu_state_t next_state;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] inst_word;
    ctrl_t           ctrl;

    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic                  rf_we;

    logic [XLEN-1:0] rj_val;
    logic [XLEN-1:0] rkd_val;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] result;

    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] next_pc;

    wb_trace_t trace;

    // SRAM data arrives in DECODE and the register holds it afterwards
    assign inst_word = (state == DECODE) ? inst_sram_rdata : ir;

    inst_decoder u_inst_decoder (
        .inst (inst_word),
        .ctrl (ctrl)
    );

    assign rf_raddr2 = ctrl.src2_from_rd ? ctrl.rd : ctrl.rk;
    assign rf_we     = (state == WRITEBACK) && ctrl.reg_we;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rj),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (ctrl.dest),
        .wdata  (result)
    );

    alu u_alu (
        .alu_op (ctrl.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    always_comb begin
        case (state)
            FETCH:   next_state = DECODE;
            DECODE:  next_state = EXECUTE;
            EXECUTE: begin
                case (ctrl.op)
                    OP_B, OP_BEQ, OP_BNE, OP_ILLEGAL: next_state = FETCH;
                    OP_LD_W, OP_ST_W:                 next_state = MEMORY;
                    default:                          next_state = WRITEBACK;
                endcase
            end
            MEMORY:  next_state = ctrl.res_from_mem ? WRITEBACK : FETCH;
            default: next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    // Branch resolution
    assign seq_pc    = pc + 32'd4;
    assign br_target = (ctrl.is_jirl ? rj_val : pc) + ctrl.br_offs;
    assign br_taken  = ctrl.is_branch &&
                       (!ctrl.is_cond_branch || ((rj_val == rkd_val) == ctrl.branch_on_eq));
    assign next_pc   = br_taken ? br_target : seq_pc;

    // PC holds for the whole instruction so the trace sees it in WRITEBACK
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (next_state == FETCH) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DECODE: begin
                ir       <= inst_sram_rdata;
                rj_val   <= rf_rdata1;
                rkd_val  <= rf_rdata2;
                alu_src1 <= ctrl.src1_is_pc ? pc : rf_rdata1;
                alu_src2 <= ctrl.src2_is_imm ? ctrl.imm : rf_rdata2;
            end
            EXECUTE: begin
                result <= alu_result;
            end
            MEMORY: begin
                if (ctrl.res_from_mem) begin
                    result <= data_sram_rdata;  // Load data replaces the address
                end
            end
            default: begin
            end
        endcase
    end

    assign inst_sram_addr = pc;

    assign data_sram_we    = (state == EXECUTE) && ctrl.mem_we;  // One-cycle store pulse
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_val;

    always_comb begin
        trace.pc    = pc;
        trace.we    = {4{rf_we}};
        trace.wnum  = ctrl.dest;
        trace.wdata = result;
    end

    assign debug_wb_pc       = trace.pc;
    assign debug_wb_rf_we    = trace.we;
    assign debug_wb_rf_wnum  = trace.wnum;
    assign debug_wb_rf_wdata = trace.wdata;

endmodule

`default_nettype wire

// File: testbench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  wnum;
    logic [31:0] wdata;
} wb_expect_t;

wb_expect_t exp_q[$];
string      exp_name_q[$];

// One word per ROM slot, slot 0 sits at the reset PC
task automatic load_program();
    rom[0]  = 32'h15ffffe4;   // lu12i.w r4, 0xfffff
    rom[1]  = 32'h02bff405;   // addi.w  r5, r0, -3
    rom[2]  = 32'h02801c06;   // addi.w  r6, r0, 7
    rom[3]  = 32'h001018a7;   // add.w   r7, r5, r6
    rom[4]  = 32'h001114c8;   // sub.w   r8, r6, r5
    rom[5]  = 32'h001218a9;   // slt     r9, r5, r6
    rom[6]  = 32'h001298aa;   // sltu    r10, r5, r6
    rom[7]  = 32'h0014188b;   // nor     r11, r4, r6
    rom[8]  = 32'h001490ac;   // and     r12, r5, r4
    rom[9]  = 32'h0015188d;   // or      r13, r4, r6
    rom[10] = 32'h001598ae;   // xor     r14, r5, r6
    rom[11] = 32'h004090cf;   // slli.w  r15, r6, 4
    rom[12] = 32'h0044f0b0;   // srli.w  r16, r5, 28
    rom[13] = 32'h004884b1;   // srai.w  r17, r5, 1
    rom[14] = 32'h028014c0;   // addi.w  r0, r6, 5
    rom[15] = 32'h00101812;   // add.w   r18, r0, r6
    rom[16] = 32'h02840014;   // addi.w  r20, r0, 0x100
    rom[17] = 32'h2980028d;   // st.w    r13, r20, 0
    rom[18] = 32'h28800295;   // ld.w    r21, r20, 0
    rom[19] = 32'h28801296;   // ld.w    r22, r20, 4
    rom[20] = 32'h29802287;   // st.w    r7, r20, 8
    rom[21] = 32'h28802297;   // ld.w    r23, r20, 8
    rom[22] = 32'h580008d2;   // beq     r6, r18, +8
    rom[23] = 32'h02800418;   // addi.w  r24, r0, 1
    rom[24] = 32'h580008c5;   // beq     r6, r5, +8
    rom[25] = 32'h02800818;   // addi.w  r24, r0, 2
    rom[26] = 32'h5c0008c5;   // bne     r6, r5, +8
    rom[27] = 32'h02800419;   // addi.w  r25, r0, 1
    rom[28] = 32'h5c0008d2;   // bne     r6, r18, +8
    rom[29] = 32'h02800c19;   // addi.w  r25, r0, 3
    rom[30] = 32'h50000800;   // b       +8
    rom[31] = 32'h0280041a;   // addi.w  r26, r0, 1
    rom[32] = 32'h54001000;   // bl      +16
    rom[33] = 32'h0280141a;   // addi.w  r26, r0, 5
    rom[34] = 32'h50000000;   // b       0, parks the CPU
    rom[36] = 32'h0280181b;   // addi.w  r27, r0, 6
    rom[37] = 32'h4c000022;   // jirl    r2, r1, 0
endtask

task automatic add_expect(input string name, input int slot, input logic [4:0] wnum,
                          input logic [31:0] wdata);
    wb_expect_t e;
    e.pc    = RESET_PC + 32'(slot * 4);
    e.wnum  = wnum;
    e.wdata = wdata;
    exp_q.push_back(e);
    exp_name_q.push_back(name);
endtask

// Retire order; skipped slots and the r0 write leave gaps
task automatic load_expected();
    add_expect("lu12i_w", 0, 5'd4, 32'hfffff000);
    add_expect("addi_w_neg", 1, 5'd5, 32'hfffffffd);
    add_expect("addi_w_pos", 2, 5'd6, 32'h00000007);
    add_expect("add_w", 3, 5'd7, 32'h00000004);
    add_expect("sub_w", 4, 5'd8, 32'h0000000a);
    add_expect("slt_neg", 5, 5'd9, 32'h00000001);
    add_expect("sltu_neg", 6, 5'd10, 32'h00000000);
    add_expect("nor", 7, 5'd11, 32'h00000ff8);
    add_expect("and", 8, 5'd12, 32'hfffff000);
    add_expect("or", 9, 5'd13, 32'hfffff007);
    add_expect("xor", 10, 5'd14, 32'hfffffffa);
    add_expect("slli_w", 11, 5'd15, 32'h00000070);
    add_expect("srli_w_neg", 12, 5'd16, 32'h0000000f);
    add_expect("srai_w_neg", 13, 5'd17, 32'hfffffffe);
    add_expect("r0_as_source", 15, 5'd18, 32'h00000007);
    add_expect("addi_w_base", 16, 5'd20, 32'h00000100);
    add_expect("ld_w_stored", 18, 5'd21, 32'hfffff007);
    add_expect("ld_w_preload", 19, 5'd22, 32'h12345678);
    add_expect("ld_w_after_st", 21, 5'd23, 32'h00000004);
    add_expect("beq_not_taken", 25, 5'd24, 32'h00000002);
    add_expect("bne_not_taken", 29, 5'd25, 32'h00000003);
    add_expect("bl_link", 32, 5'd1, 32'h1c000084);
    add_expect("bl_target", 36, 5'd27, 32'h00000006);
    add_expect("jirl_link", 37, 5'd2, 32'h1c000098);
    add_expect("jirl_target", 33, 5'd26, 32'h00000005);
endtask

`endif

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam logic [31:0] RESET_PC   = 32'h1c00_0000;
    localparam int          CLK_PERIOD = 100;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] inst_addr_q;
    logic [31:0] data_addr_q;

    bit test_ok;
    int pass_count;
    int fail_count;

    `include "tb_program.svh"

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] rom_slot(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - RESET_PC;
        return offs[9:2];
    endfunction

    // Both SRAMs answer one cycle after the address, outputs change mid-cycle
    always @(negedge clk) begin
        inst_sram_rdata = rom[rom_slot(inst_addr_q)];
        inst_addr_q     = inst_sram_addr;
        data_sram_rdata = ram[data_addr_q[9:2]];
        if (data_sram_we) begin
            ram[data_sram_addr[9:2]] = data_sram_wdata;
        end
        data_addr_q = data_sram_addr;
    end

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
            test_ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_ok) begin
            pass_count++;
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
        end
    endtask

    task automatic check_ram_word(input string name, input logic [31:0] addr,
                                  input logic [31:0] expected);
        test_ok = 1'b1;
        check_value(name, "ram word", expected, ram[addr[9:2]]);
        finish_test(name);
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        inst_addr_q     = RESET_PC;
        data_addr_q     = '0;
        pass_count      = 0;
        fail_count      = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;                  // Zero decodes as illegal
            ram[i] = '0;
        end
        load_program();
        load_expected();
        ram[8'h41] = 32'h12345678;        // Preloaded word at 0x104
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < exp_q.size(); i++) begin
            do begin
                @(negedge clk);
            end while (debug_wb_rf_we == 4'h0);
            test_ok = 1'b1;
            check_value(exp_name_q[i], "we", 32'hf, {28'h0, debug_wb_rf_we});
            check_value(exp_name_q[i], "pc", exp_q[i].pc, debug_wb_pc);
            check_value(exp_name_q[i], "wnum", {27'h0, exp_q[i].wnum},
                        {27'h0, debug_wb_rf_wnum});
            check_value(exp_name_q[i], "wdata", exp_q[i].wdata, debug_wb_rf_wdata);
            finish_test(exp_name_q[i]);
        end

        check_ram_word("ram_st_w_0x100", 32'h100, 32'hfffff007);
        check_ram_word("ram_preload_0x104", 32'h104, 32'h12345678);
        check_ram_word("ram_st_w_0x108", 32'h108, 32'h00000004);

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Budget of five cycles per expected write plus some slack
    initial begin
        @(negedge reset);
        #((exp_q.size() * 5 + 20) * CLK_PERIOD);
        $display("Watchdog expired: the trace stalled after %0d of %0d register writes",
                 pass_count + fail_count, exp_q.size());
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+testbench
rtl/la_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/regfile.sv
rtl/cpu_top.sv
testbench/tb_cpu_top.sv

// File: Bender.yml
package:
  name: la_multicycle_cpu

sources:
  - files:
      - rtl/la_isa_pkg.sv
      - rtl/cpu_ctrl_pkg.sv
      - rtl/inst_decoder.sv
      - rtl/alu.sv
      - rtl/regfile.sv
      - rtl/cpu_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_cpu_top.sv
